/* compile.f */
rtl/rv_isa_pkg.sv
rtl/id_pkg.sv
rtl/id_decoder.sv
rtl/id_gpr_file.sv
rtl/id_operand_bypass.sv
rtl/id_branch_unit.sv
rtl/id_stage.sv
dv/id_stage_assertions.sv
dv/tb_id_stage.sv

/* Makefile */
TOP = tb_id_stage

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

build:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP)

sim: build
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "^test passed$$"

clean:
	rm -rf obj_dir

.PHONY: all lint build sim clean

/* dv/tb_id_stage.sv */
// testbench for the decode stage, preloads the register file and applies a table of stimulus rows
`timescale 1ns/1ps

module tb_id_stage;

  import id_pkg::*;
  import rv_isa_pkg::*;

  localparam int CHK_WD = $bits(de_bus_t); // widest value compared

  typedef struct {
    logic [31:0] inst;
    word_t       pc;
    logic [2:0]  ctl;      // fetch valid behind it, es allowin, es load
    bypass_bus_t es, ms, ws;
    logic        exp_valid;
    logic [1:0]  src;      // rs1/rs2 expected from the file model
    word_t       exp_rs1, exp_rs2;
    gpr_addr_t   exp_rd;
    alu_op_e     exp_op;
    word_t       exp_imm;
    logic [3:0]  exp_flags; // word_cut, mem_ren, mem_wen, invalid
    logic        exp_taken;
    word_t       exp_target;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        fs_valid;
  fd_bus_t     fs_bus;
  logic        ds_allowin;
  logic        es_allowin;
  logic        es_load_sel;
  bypass_bus_t es_bp, ms_bp, ws_bp;
  wb_bus_t     rf_bus;
  logic        ds_to_es_valid;
  de_bus_t     de_bus;
  br_bus_t     br_bus;

  word_t model [32];
  row_t  rows [$];
  int    cycles = 0;

  id_stage UUT (
    .i_clk(clk), .i_rst_n(rst_n), .i_fs_to_ds_valid(fs_valid), .i_fs_to_ds_bus(fs_bus),
    .o_ds_allowin(ds_allowin), .i_es_allowin(es_allowin), .i_es_load_sel(es_load_sel),
    .i_es_bypass(es_bp), .i_ms_bypass(ms_bp), .i_ws_bypass(ws_bp), .i_ws_to_rf_bus(rf_bus),
    .o_ds_to_es_valid(ds_to_es_valid), .o_ds_to_es_bus(de_bus), .o_br_bus(br_bus)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > rows.size() * 4 + 50) begin
      $display("the run timed out after %0d cycles", cycles);
      $display("test failed");
      $fatal(1, "timeout");
    end
  end

  task automatic check(input string name, input logic [CHK_WD-1:0] got,
                       input logic [CHK_WD-1:0] exp);
    if (got !== exp) begin
      $display("Error: time %0t, %s = %h, expected %h", $time, name, got, exp);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic add_row(input logic [31:0] inst, input word_t pc, input logic [2:0] ctl,
                         input bypass_bus_t es, input bypass_bus_t ms, input bypass_bus_t ws,
                         input logic v, input logic [1:0] src, input word_t rs1,
                         input word_t rs2, input gpr_addr_t rd, input alu_op_e op,
                         input word_t imm, input logic [3:0] flags, input logic taken,
                         input word_t target);
    rows.push_back('{inst, pc, ctl, es, ms, ws, v, src, rs1, rs2, rd, op, imm, flags,
                     taken, target});
  endtask

  task automatic apply_row(input row_t r);
    de_bus_t snap;
    @(negedge clk);
    fs_valid = 1'b1;
    fs_bus   = '{inst: r.inst, pc: r.pc};
    @(negedge clk); // latched at the rising edge
    fs_valid    = r.ctl[2];
    fs_bus      = '{inst: 32'h002082b3, pc: r.pc + 64'd4};
    es_allowin  = r.ctl[1];
    es_load_sel = r.ctl[0];
    es_bp       = r.es;
    ms_bp       = r.ms;
    ws_bp       = r.ws;
    #1;
    check("o_ds_to_es_valid", ds_to_es_valid, r.exp_valid);
    if (r.ctl[0]) begin // load-use, released one cycle later
      check("o_ds_allowin", ds_allowin, 1'b0);
      @(negedge clk);
      es_load_sel = 1'b0;
      #1;
      check("o_ds_to_es_valid", ds_to_es_valid, 1'b1);
    end
    check("rs1_data", de_bus.rs1_data, r.src[1] ? model[r.inst[19:15]] : r.exp_rs1);
    check("rs2_data", de_bus.rs2_data, r.src[0] ? model[r.inst[24:20]] : r.exp_rs2);
    check("rd", de_bus.rd, r.exp_rd);
    check("alu_op", de_bus.alu_op, r.exp_op);
    check("imm", de_bus.imm, r.exp_imm);
    check("pc", de_bus.pc, r.pc);
    check("flags", {de_bus.word_cut, de_bus.mem_ren, de_bus.mem_wen, de_bus.invalid},
          r.exp_flags);
    check("br_bus.taken", br_bus.taken, r.exp_taken);
    check("br_bus.target", br_bus.target, r.exp_target);
    if (!r.ctl[1]) begin // execute back-pressure
      snap = de_bus;
      repeat (3) begin
        @(negedge clk);
        #1;
        check("o_ds_allowin", ds_allowin, 1'b0);
        check("o_ds_to_es_bus", de_bus, snap);
      end
      es_allowin = 1'b1;
      #1;
      check("o_ds_allowin", ds_allowin, 1'b1);
    end
    if (r.ctl[2] && r.exp_taken) begin // wrong-path fetch becomes a nop
      @(negedge clk);
      fs_valid = 1'b0;
      #1;
      check("nop pc", de_bus.pc, r.pc + 64'd4);
      check("nop rd", de_bus.rd, 5'd0);
      check("nop alu_op", de_bus.alu_op, ALU_ADD);
      check("nop imm", de_bus.imm, 64'd0);
      check("nop gpr_wen", de_bus.gpr_wen, 1'b1);
      check("nop valid", ds_to_es_valid, 1'b1);
      check("nop taken", br_bus.taken, 1'b0);
    end
    fs_valid    = 1'b0;
    es_allowin  = 1'b1;
    es_load_sel = 1'b0;
    es_bp       = '0;
    ms_bp       = '0;
    ws_bp       = '0;
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    fs_valid    = 1'b0;
    fs_bus      = '0;
    es_allowin  = 1'b1;
    es_load_sel = 1'b0;
    es_bp       = '0;
    ms_bp       = '0;
    ws_bp       = '0;
    rf_bus      = '0;
    void'($urandom(32'hce12ec83));
    add_row(32'h002082b3, 64'h100, 3'b010, '0, '0, '0, 1, 2'b11, 0, 0, 5, ALU_ADD, 0, 4'b0000,
            0, 64'h100);
    add_row(32'h4041833b, 64'h104, 3'b010, '0, '0, '0, 1, 2'b11, 0, 0, 6, ALU_SUB, 0, 4'b1000,
            0, 64'h104);
    add_row(32'hffb40393, 64'h108, 3'b000, '0, '0, '0, 1, 2'b10, 0, 0, 7, ALU_ADD, -64'sd5,
            4'b0000, 0, 64'h103);
    add_row(32'h800004b7, 64'h10c, 3'b010, '0, '0, '0, 1, 2'b00, 0, 0, 9, ALU_PASS2,
            64'hffffffff80000000, 4'b0000, 0, 64'hffffffff8000010c);
    add_row(32'h0105b503, 64'h110, 3'b010, '0, '0, '0, 1, 2'b10, 0, 0, 10, ALU_ADD, 16, 4'b0100,
            0, 64'h120);
    add_row(32'hfec6bc23, 64'h114, 3'b010, '0, '0, '0, 1, 2'b11, 0, 0, 24, ALU_ADD, -64'sd8,
            4'b0010, 0, 64'h10c);
    add_row(32'h0000007f, 64'h118, 3'b010, '0, '0, '0, 1, 2'b00, 0, 0, 0, ALU_ADD, 0, 4'b0001,
            0, 64'h118);
    add_row(32'h002082b3, 64'h200, 3'b010, '{1, 64'ha}, '{1, 64'hb}, '{2, 64'hc}, 1, 2'b00,
            64'ha, 64'hc, 5, ALU_ADD, 0, 4'b0000, 0, 64'h200);
    add_row(32'h002002b3, 64'h204, 3'b010, '{0, 64'hd}, '{2, 64'he}, '{2, 64'hf}, 1, 2'b00,
            0, 64'he, 5, ALU_ADD, 0, 4'b0000, 0, 64'h204);
    add_row(32'h002082b3, 64'h208, 3'b011, '{1, 64'h77}, '0, '0, 0, 2'b01, 64'h77, 0, 5,
            ALU_ADD, 0, 4'b0000, 0, 64'h208);
    add_row(32'h00208863, 64'h1000, 3'b010, '{1, 5}, '{2, 5}, '0, 1, 2'b00, 5, 5, 16, ALU_ADD,
            16, 4'b0000, 1, 64'h1010);
    add_row(32'h00208863, 64'h1000, 3'b010, '{1, 5}, '{2, 6}, '0, 1, 2'b00, 5, 6, 16, ALU_ADD,
            16, 4'b0000, 0, 64'h1010);
    add_row(32'h00209863, 64'h1100, 3'b110, '{1, 5}, '{2, 6}, '0, 1, 2'b00, 5, 6, 16, ALU_ADD,
            16, 4'b0000, 1, 64'h1110);
    add_row(32'h0020c863, 64'h1200, 3'b010, '{1, -64'sd1}, '{2, 1}, '0, 1, 2'b00, -64'sd1, 1,
            16, ALU_ADD, 16, 4'b0000, 1, 64'h1210);
    add_row(32'h0020c863, 64'h1200, 3'b010, '{1, 1}, '{2, -64'sd1}, '0, 1, 2'b00, 1, -64'sd1,
            16, ALU_ADD, 16, 4'b0000, 0, 64'h1210);
    add_row(32'h0020f863, 64'h1300, 3'b010, '{1, -64'sd1}, '{2, 1}, '0, 1, 2'b00, -64'sd1, 1,
            16, ALU_ADD, 16, 4'b0000, 1, 64'h1310);
    add_row(32'h0020f863, 64'h1300, 3'b010, '{1, 1}, '{2, -64'sd1}, '0, 1, 2'b00, 1, -64'sd1,
            16, ALU_ADD, 16, 4'b0000, 0, 64'h1310);
    add_row(32'h100000ef, 64'h2000, 3'b110, '0, '0, '0, 1, 2'b00, 0, 0, 1, ALU_ADD, 64'h100,
            4'b0000, 1, 64'h2100);
    add_row(32'h004000ef, 64'h3000, 3'b010, '0, '0, '0, 1, 2'b00, 0, 0, 1, ALU_ADD, 4, 4'b0000,
            0, 64'h3004);
    add_row(32'h00518067, 64'h4000, 3'b010, '{3, 64'h5000}, '0, '0, 1, 2'b00, 64'h5000, 0, 0,
            ALU_ADD, 5, 4'b0000, 1, 64'h5004);
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check("o_ds_allowin", ds_allowin, 1'b1);
    check("o_ds_to_es_valid", ds_to_es_valid, 1'b0);
    check("br_bus.taken", br_bus.taken, 1'b0);
    model[0] = '0;
    for (int i = 1; i < 32; i++) begin
      @(negedge clk);
      model[i] = {$urandom, $urandom};
      rf_bus   = '{en: 1'b1, addr: i[4:0], data: model[i]};
    end
    @(negedge clk);
    rf_bus = '0;
    foreach (rows[i]) apply_row(rows[i]);
    @(negedge clk);
    $display("test passed");
    $finish;
  end

endmodule

/* dv/id_stage_assertions.sv */
// concurrent checks on the decode stage handshake and redirect, bound into every id_stage
`timescale 1ns/1ps

module id_stage_assertions (
  input logic            i_clk,
  input logic            i_rst_n,
  input logic            i_fs_to_ds_valid,
  input logic            o_ds_allowin,
  input logic            ds_valid,
  input logic            o_ds_to_es_valid,
  input logic            i_es_allowin,
  input id_pkg::br_bus_t o_br_bus,
  input id_pkg::de_bus_t o_ds_to_es_bus
);

  // stalled or blocked instruction stays put
  a_stage_holds: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (ds_valid && !(o_ds_to_es_valid && i_es_allowin)) |=> ds_valid)
    else $error("instruction left the stage without issuing");

  // squashed slot writes nothing and never redirects again
  a_flush_gives_nop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_br_bus.taken && i_fs_to_ds_valid && o_ds_allowin) |=>
      (!o_br_bus.sel && (o_ds_to_es_bus.rd == '0) && !o_ds_to_es_bus.mem_wen))
    else $error("instruction behind a taken redirect was not squashed");

  // execute stalled, bus must hold
  a_hold_on_backpressure: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_ds_to_es_valid && !i_es_allowin) |=> $stable(o_ds_to_es_bus))
    else $error("decode bus changed under back-pressure");

endmodule

bind id_stage id_stage_assertions u_assertions (
  .i_clk(i_clk), .i_rst_n(i_rst_n), .i_fs_to_ds_valid(i_fs_to_ds_valid),
  .o_ds_allowin(o_ds_allowin), .ds_valid(ds_valid), .o_ds_to_es_valid(o_ds_to_es_valid),
  .i_es_allowin(i_es_allowin), .o_br_bus(o_br_bus), .o_ds_to_es_bus(o_ds_to_es_bus)
);

/* rtl/id_stage.sv */
// RV64I decode stage top, stage register with valid/allowin handshake to fetch and execute
`timescale 1ns/1ps

module id_stage (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_fs_to_ds_valid,
  input  id_pkg::fd_bus_t     i_fs_to_ds_bus,
  output logic                o_ds_allowin,
  input  logic                i_es_allowin,
  input  logic                i_es_load_sel,
  input  id_pkg::bypass_bus_t i_es_bypass,
  input  id_pkg::bypass_bus_t i_ms_bypass,
  input  id_pkg::bypass_bus_t i_ws_bypass,
  input  id_pkg::wb_bus_t     i_ws_to_rf_bus,
  output logic                o_ds_to_es_valid,
  output id_pkg::de_bus_t     o_ds_to_es_bus,
  output id_pkg::br_bus_t     o_br_bus
);

  import id_pkg::*;
  import rv_isa_pkg::*;

  logic      ds_valid;
  logic      ds_ready_go;
  logic      load_stall;
  fd_bus_t   fs_to_ds_bus_r;
  gpr_addr_t rs1, rs2, rd;
  word_t     imm;
  word_t     rf_rdata1, rf_rdata2;
  word_t     rs1_data, rs2_data;
  id_ctrl_t  ctrl;

  assign ds_ready_go      = ~load_stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  // instruction fetched behind a taken redirect is squashed to a nop
  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      fs_to_ds_bus_r <= o_br_bus.taken ? '{inst: NOP_INST, pc: i_fs_to_ds_bus.pc}
                                       : i_fs_to_ds_bus;
    end
  end

  id_decoder u_decoder (
    .i_inst (fs_to_ds_bus_r.inst),
    .o_rs1  (rs1),
    .o_rs2  (rs2),
    .o_rd   (rd),
    .o_imm  (imm),
    .o_ctrl (ctrl)
  );

  id_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2),
    .i_wb     (i_ws_to_rf_bus)
  );

  id_operand_bypass u_bypass (
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_rf_rdata1   (rf_rdata1),
    .i_rf_rdata2   (rf_rdata2),
    .i_es          (i_es_bypass),
    .i_ms          (i_ms_bypass),
    .i_ws          (i_ws_bypass),
    .i_es_load_sel (i_es_load_sel),
    .o_rs1_data    (rs1_data),
    .o_rs2_data    (rs2_data),
    .o_load_stall  (load_stall)
  );

  id_branch_unit u_branch (
    .i_issue    (o_ds_to_es_valid),
    .i_ctrl     (ctrl),
    .i_pc       (fs_to_ds_bus_r.pc),
    .i_imm      (imm),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .i_fetch_pc (i_fs_to_ds_bus.pc), // pc now in fetch
    .o_br_bus   (o_br_bus)
  );

  assign o_ds_to_es_bus = '{load_sel:     ctrl.load_sel,
                            rs1_data:     rs1_data,
                            rs2_data:     rs2_data,
                            imm:          imm,
                            pc:           fs_to_ds_bus_r.pc,
                            rd:           rd,
                            alu_src1_sel: ctrl.alu_src1_sel,
                            alu_src2_sel: ctrl.alu_src2_sel,
                            word_cut:     ctrl.word_cut,
                            alu_op:       ctrl.alu_op,
                            gpr_wen:      ctrl.gpr_wen,
                            mem_ren:      ctrl.mem_ren,
                            mem_wen:      ctrl.mem_wen,
                            mem_op:       ctrl.mem_op,
                            invalid:      ctrl.invalid};

endmodule

/* rtl/id_branch_unit.sv */
// branch and jump resolution in decode, drives the redirect bus back to fetch
`timescale 1ns/1ps

module id_branch_unit (
  input  logic             i_issue,
  input  id_pkg::id_ctrl_t i_ctrl,
  input  id_pkg::word_t    i_pc,
  input  id_pkg::word_t    i_imm,
  input  id_pkg::word_t    i_rs1_data,
  input  id_pkg::word_t    i_rs2_data,
  input  id_pkg::word_t    i_fetch_pc,
  output id_pkg::br_bus_t  o_br_bus
);

  import id_pkg::*;
  import rv_isa_pkg::*;

  logic  cond;
  logic  sel;
  word_t target;

  always_comb begin
    case (i_ctrl.br_func)
      BR_BEQ:  cond = (i_rs1_data == i_rs2_data);
      BR_BNE:  cond = (i_rs1_data != i_rs2_data);
      BR_BLT:  cond = ($signed(i_rs1_data) <  $signed(i_rs2_data));
      BR_BGE:  cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      BR_BLTU: cond = (i_rs1_data <  i_rs2_data);
      BR_BGEU: cond = (i_rs1_data >= i_rs2_data);
      default: cond = 1'b0;
    endcase
  end

  assign target = (i_ctrl.jump == JUMP_JALR) ? ((i_rs1_data + i_imm) & ~64'd1)
                                             : (i_pc + i_imm);

  assign sel = i_issue && ((i_ctrl.jump != JUMP_NONE) || (i_ctrl.br_en && cond));

  // fetch already on target means nothing to flush
  assign o_br_bus = '{taken:  sel && (target != i_fetch_pc),
                      sel:    sel,
                      target: target};

endmodule

/* rtl/id_operand_bypass.sv */
// operand forwarding from execute, memory and write-back plus load-use stall detect
`timescale 1ns/1ps

module id_operand_bypass (
  input  id_pkg::gpr_addr_t   i_rs1,
  input  id_pkg::gpr_addr_t   i_rs2,
  input  id_pkg::word_t       i_rf_rdata1,
  input  id_pkg::word_t       i_rf_rdata2,
  input  id_pkg::bypass_bus_t i_es,
  input  id_pkg::bypass_bus_t i_ms,
  input  id_pkg::bypass_bus_t i_ws,
  input  logic                i_es_load_sel,
  output id_pkg::word_t       o_rs1_data,
  output id_pkg::word_t       o_rs2_data,
  output logic                o_load_stall
);

  import id_pkg::*;

  // youngest producer first
  function automatic word_t pick(input gpr_addr_t rs, input word_t rf_data,
                                 input bypass_bus_t es, input bypass_bus_t ms,
                                 input bypass_bus_t ws);
    word_t data;
    if ((es.rd != '0) && (es.rd == rs))      data = es.result;
    else if ((ms.rd != '0) && (ms.rd == rs)) data = ms.result;
    else if ((ws.rd != '0) && (ws.rd == rs)) data = ws.result;
    else                                     data = rf_data;
    return data;
  endfunction

  assign o_rs1_data = pick(i_rs1, i_rf_rdata1, i_es, i_ms, i_ws);
  assign o_rs2_data = pick(i_rs2, i_rf_rdata2, i_es, i_ms, i_ws);

  // load result not ready until it reaches memory stage
  assign o_load_stall = i_es_load_sel && (i_es.rd != '0) &&
                        ((i_es.rd == i_rs1) || (i_es.rd == i_rs2));

endmodule

/* rtl/id_gpr_file.sv */
// general register file, two async reads for decode and one write port from write-back
`timescale 1ns/1ps

module id_gpr_file (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  id_pkg::gpr_addr_t i_raddr1,
  input  id_pkg::gpr_addr_t i_raddr2,
  output id_pkg::word_t     o_rdata1,
  output id_pkg::word_t     o_rdata2,
  input  id_pkg::wb_bus_t   i_wb
);

  import id_pkg::*;

  word_t regs [32];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.en && (i_wb.addr != '0)) begin // x0 stays zero
      regs[i_wb.addr] <= i_wb.data;
    end
  end

  // no write-through, write-back bypass covers same-cycle reads
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* rtl/id_decoder.sv */
// combinational RV64I decoder, instruction word to register fields, immediate and control
`timescale 1ns/1ps

module id_decoder (
  input  logic [id_pkg::INST_WD-1:0] i_inst,
  output id_pkg::gpr_addr_t          o_rs1,
  output id_pkg::gpr_addr_t          o_rs2,
  output id_pkg::gpr_addr_t          o_rd,
  output id_pkg::word_t              o_imm,
  output id_pkg::id_ctrl_t           o_ctrl
);

  import id_pkg::*;
  import rv_isa_pkg::*;

  function automatic alu_op_e alu_of(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  logic       use_rs1, use_rs2;
  logic       bad;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // unused source fields read as x0 so they never stall
  assign o_rd  = i_inst[11:7];
  assign o_rs1 = use_rs1 ? i_inst[19:15] : '0;
  assign o_rs2 = use_rs2 ? i_inst[24:20] : '0;

  always_comb begin
    o_ctrl  = '0;
    o_imm   = '0;
    bad     = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      OP_LUI, OP_AUIPC: begin
        o_ctrl.alu_src1_sel = (opcode == OP_AUIPC);
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.alu_op       = (opcode == OP_LUI) ? ALU_PASS2 : ALU_ADD;
        o_ctrl.gpr_wen      = 1'b1;
        o_imm               = imm_u;
      end
      OP_JAL, OP_JALR: begin // link value pc + 4
        use_rs1             = (opcode == OP_JALR);
        o_ctrl.alu_src1_sel = 1'b1;
        o_ctrl.alu_src2_sel = SRC2_FOUR;
        o_ctrl.gpr_wen      = 1'b1;
        o_ctrl.jump         = (opcode == OP_JAL) ? JUMP_JAL : JUMP_JALR;
        o_imm               = (opcode == OP_JAL) ? imm_j : imm_i;
        bad                 = (opcode == OP_JALR) && (funct3 != 3'b000);
      end
      OP_BRANCH: begin
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
        o_ctrl.br_en   = 1'b1;
        o_ctrl.br_func = br_func_e'(funct3);
        o_imm          = imm_b;
        bad            = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      OP_LOAD: begin
        use_rs1             = 1'b1;
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen      = 1'b1;
        o_ctrl.mem_ren      = 1'b1;
        o_ctrl.load_sel     = 1'b1;
        o_ctrl.mem_op       = funct3;
        o_imm               = imm_i;
        bad                 = (funct3 == 3'b111);
      end
      OP_STORE: begin
        use_rs1             = 1'b1;
        use_rs2             = 1'b1;
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.mem_wen      = 1'b1;
        o_ctrl.mem_op       = funct3;
        o_imm               = imm_s;
        bad                 = funct3[2];
      end
      OP_IMM, OP_IMM_32: begin
        use_rs1             = 1'b1;
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.word_cut     = (opcode == OP_IMM_32);
        o_ctrl.gpr_wen      = 1'b1;
        o_ctrl.alu_op       = alu_of(funct3, (funct3 == 3'b101) && i_inst[30]);
        o_imm               = imm_i;
        if (opcode == OP_IMM) begin // 6-bit shamt
          if (funct3 == 3'b001) bad = (i_inst[31:26] != 6'b0);
          if (funct3 == 3'b101) bad = (i_inst[31:26] != 6'b0) && (i_inst[31:26] != 6'b010000);
        end else begin
          case (funct3)
            3'b000:  bad = 1'b0;
            3'b001:  bad = (funct7 != 7'b0);
            3'b101:  bad = (funct7 != 7'b0) && (funct7 != 7'b0100000);
            default: bad = 1'b1;
          endcase
        end
      end
      OP_OP, OP_32: begin
        use_rs1             = 1'b1;
        use_rs2             = 1'b1;
        o_ctrl.alu_src2_sel = SRC2_RS2;
        o_ctrl.word_cut     = (opcode == OP_32);
        o_ctrl.gpr_wen      = 1'b1;
        o_ctrl.alu_op       = alu_of(funct3, i_inst[30]);
        bad = !((funct7 == 7'b0) ||
                ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101))));
        if ((opcode == OP_32) && (funct3 != 3'b000) && (funct3 != 3'b001) && (funct3 != 3'b101))
          bad = 1'b1;
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      o_ctrl.gpr_wen  = 1'b0;
      o_ctrl.mem_ren  = 1'b0;
      o_ctrl.mem_wen  = 1'b0;
      o_ctrl.br_en    = 1'b0;
      o_ctrl.jump     = JUMP_NONE;
      o_ctrl.load_sel = 1'b0;
    end
    o_ctrl.invalid = bad;
  end

endmodule

/* rtl/id_pkg.sv */
// decode stage bus widths and structs, shared by the stage, its submodules and the testbench
package id_pkg;

  localparam int XLEN        = 64;
  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;

  typedef logic [XLEN-1:0]        word_t;
  typedef logic [GPR_ADDR_WD-1:0] gpr_addr_t;

  typedef enum logic [1:0] {JUMP_NONE, JUMP_JAL, JUMP_JALR} jump_e;
  typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_sel_e;

  typedef struct packed {
    logic [INST_WD-1:0] inst;
    word_t              pc;
  } fd_bus_t;

  typedef struct packed {
    logic      en;
    gpr_addr_t addr;
    word_t     data;
  } wb_bus_t;

  // rd of 0 means no forward
  typedef struct packed {
    gpr_addr_t rd;
    word_t     result;
  } bypass_bus_t;

  typedef struct packed {
    logic  taken; // sel and target != pc in fetch
    logic  sel;
    word_t target;
  } br_bus_t;

  typedef struct packed {
    logic                alu_src1_sel; // 1 selects pc
    src2_sel_e           alu_src2_sel;
    logic                word_cut;     // 32-bit op, sign-extend result
    rv_isa_pkg::alu_op_e alu_op;
    logic                gpr_wen;
    logic                mem_ren;
    logic                mem_wen;
    logic [2:0]          mem_op;       // funct3 of load/store
    logic                br_en;
    rv_isa_pkg::br_func_e br_func;
    jump_e               jump;
    logic                load_sel;
    logic                invalid;
  } id_ctrl_t;

  typedef struct packed {
    logic                load_sel;
    word_t               rs1_data;
    word_t               rs2_data;
    word_t               imm;
    word_t               pc;
    gpr_addr_t           rd;
    logic                alu_src1_sel;
    src2_sel_e           alu_src2_sel;
    logic                word_cut;
    rv_isa_pkg::alu_op_e alu_op;
    logic                gpr_wen;
    logic                mem_ren;
    logic                mem_wen;
    logic [2:0]          mem_op;
    logic                invalid;
  } de_bus_t;

endpackage

/* rtl/rv_isa_pkg.sv */
// RV64I encodings used by the decoder, branch unit and stage register
package rv_isa_pkg;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_OP     = 7'b0110011,
    OP_IMM_32 = 7'b0011011,
    OP_32     = 7'b0111011
  } opcode_e;

  // values follow funct3
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_func_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_PASS2 // lui, result is source 2
  } alu_op_e;

  localparam logic [31:0] NOP_INST = 32'h00000013; // addi x0, x0, 0

endpackage
